// ==== dm_pkg.sv ====
// DMI widths, request/response types, op and response codes, register map, status value
package dm_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  // ----------------------------------------
  // request op and response code
  // ----------------------------------------
  typedef enum logic [1:0] {
    DmiNop      = 2'h0,
    DmiRead     = 2'h1,
    DmiWrite    = 2'h2,
    DmiReserved = 2'h3  // answered with failed
  } dmi_op_e;

  typedef enum logic [1:0] {
    DmiRespOk     = 2'h0,
    DmiRespFailed = 2'h2
  } dmi_resp_e;

  // host to debug module, 41 bits
  typedef struct packed {
    logic [DmiAddrWidth-1:0] addr;
    dmi_op_e                 op;
    logic [DmiDataWidth-1:0] data;
  } dmi_req_t;

  // debug module to host, 34 bits
  typedef struct packed {
    logic [DmiDataWidth-1:0] data;
    dmi_resp_e               resp;
  } dmi_resp_t;

  // ----------------------------------------
  // register map
  // ----------------------------------------
  localparam logic [DmiAddrWidth-1:0] AddrData0     = 7'h04;
  localparam logic [DmiAddrWidth-1:0] AddrDmControl = 7'h10;
  localparam logic [DmiAddrWidth-1:0] AddrDmStatus  = 7'h11;

  // stored bits of dmcontrol
  localparam int unsigned DmControlActiveBit   = 0;
  localparam int unsigned DmControlNdmresetBit = 1;
  localparam int unsigned DmControlHaltreqBit  = 31;

  // dmstatus is constant here: version 2, authenticated
  localparam logic [DmiDataWidth-1:0] DmStatusValue = 32'h0000_0082;

endpackage

// ==== dmi_cut.sv ====
// one-stage valid/ready register slice with a generic payload type
module dmi_cut
  import dm_pkg::*;
#(
  parameter type payload_t = dmi_req_t
) (
  input  logic     clk_i,
  input  logic     ndmreset_n,
  // upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     full_q;
  payload_t data_q;
  logic     load;

  // accept when empty or when the held item leaves this cycle
  assign ready_o = ~full_q | ready_i;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_full
    if (!ndmreset_n) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      full_q <= 1'b0;  // drained, nothing new
    end
  end

  always_ff @(posedge clk_i) begin : p_data
    if (load) begin
      data_q <= data_i;
    end
  end

  assign valid_o = full_q;
  assign data_o  = data_q;

endmodule

// ==== dmi_fsm.sv ====
// DMI request handler FSM: accepts one request, strobes the registers, returns a response
module dmi_fsm
  import dm_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  // request in
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  dmi_req_t                req_i,
  // response out
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output dmi_resp_t               resp_o,
  // register strobe
  output logic                    reg_en_o,
  output logic                    reg_we_o,
  output logic [DmiAddrWidth-1:0] reg_addr_o,
  output logic [DmiDataWidth-1:0] reg_wdata_o,
  input  logic [DmiDataWidth-1:0] reg_rdata_i
);

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    RESP
  } state_e;

  state_e    state_d, state_q;
  dmi_req_t  req_q;
  dmi_resp_t resp_d, resp_q;
  logic      is_access;

  // only reads and writes touch the register file
  assign is_access = (req_q.op == DmiRead) || (req_q.op == DmiWrite);

  assign req_ready_o  = (state_q == IDLE);
  assign resp_valid_o = (state_q == RESP);
  assign resp_o       = resp_q;

  assign reg_en_o    = (state_q == EXEC) & is_access;
  assign reg_we_o    = (state_q == EXEC) & (req_q.op == DmiWrite);
  assign reg_addr_o  = req_q.addr;
  assign reg_wdata_o = req_q.data;

  // ----------------------------------------
  // next state and response decode
  // ----------------------------------------
  always_comb begin : p_next
    state_d = state_q;
    unique case (state_q)
      IDLE: if (req_valid_i) state_d = EXEC;
      EXEC: state_d = RESP;  // single cycle
      RESP: if (resp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_comb begin : p_resp
    resp_d.data = '0;
    resp_d.resp = DmiRespOk;
    if (req_q.op == DmiRead) begin
      resp_d.data = reg_rdata_i;
    end else if (req_q.op == DmiReserved) begin
      resp_d.resp = DmiRespFailed;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_state
    if (!ndmreset_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (state_q == IDLE && req_valid_i) begin
      req_q <= req_i;  // latch on transfer
    end
    if (state_q == EXEC) begin
      resp_q <= resp_d;
    end
  end

endmodule

// ==== dm_regs.sv ====
// debug register file: data0, dmcontrol and dmstatus with halt and reset request outputs
module dm_regs
  import dm_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    reg_en_i,
  input  logic                    reg_we_i,
  input  logic [DmiAddrWidth-1:0] reg_addr_i,
  input  logic [DmiDataWidth-1:0] reg_wdata_i,
  output logic [DmiDataWidth-1:0] reg_rdata_o,
  output logic                    haltreq_o,
  output logic                    dm_rst_o
);

  logic [DmiDataWidth-1:0] data0_q;
  logic                    dmactive_q;
  logic                    ndmreset_q;
  logic                    haltreq_q;
  logic                    wr_en;
  logic                    wr_active;

  assign wr_en     = reg_en_i & reg_we_i;
  assign wr_active = reg_wdata_i[DmControlActiveBit];

  // ----------------------------------------
  // write side
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_regs
    if (!ndmreset_n) begin
      data0_q    <= '0;
      dmactive_q <= 1'b0;
      ndmreset_q <= 1'b0;
      haltreq_q  <= 1'b0;
    end else if (wr_en) begin
      if (reg_addr_i == AddrData0) begin
        data0_q <= reg_wdata_i;
      end else if (reg_addr_i == AddrDmControl) begin
        dmactive_q <= wr_active;
        // request bits only stick while the module is active
        ndmreset_q <= wr_active & reg_wdata_i[DmControlNdmresetBit];
        haltreq_q  <= wr_active & reg_wdata_i[DmControlHaltreqBit];
      end
    end
  end

  // ----------------------------------------
  // read side, same cycle
  // ----------------------------------------
  always_comb begin : p_read
    reg_rdata_o = '0;
    unique case (reg_addr_i)
      AddrData0: reg_rdata_o = data0_q;
      AddrDmControl: begin
        reg_rdata_o[DmControlActiveBit]   = dmactive_q;
        reg_rdata_o[DmControlNdmresetBit] = ndmreset_q;
        reg_rdata_o[DmControlHaltreqBit]  = haltreq_q;
      end
      AddrDmStatus: reg_rdata_o = DmStatusValue;
      default: reg_rdata_o = '0;  // unmapped
    endcase
  end

  assign haltreq_o = haltreq_q & dmactive_q;
  assign dm_rst_o  = ndmreset_q;

endmodule

// ==== debug_holdoff.sv ====
// post-reset hold-off counter that gates the halt request to the core
module debug_holdoff
  import dm_pkg::*;
#(
  parameter int unsigned HoldoffCycles = 500
) (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic haltreq_i,
  output logic debug_req_o
);

  // wide enough to hold HoldoffCycles itself
  localparam int unsigned CntWidth = (HoldoffCycles > 0) ? $clog2(HoldoffCycles + 1) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic                cnt_zero;

  assign cnt_zero = (cnt_q == '0);

  // lets boot code run before a halt can hit the core
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_cnt
    if (!ndmreset_n) begin
      cnt_q <= CntWidth'(HoldoffCycles);
    end else if (!cnt_zero) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = cnt_zero & haltreq_i;  // blocked during hold-off

endmodule

// ==== dm_subsystem.sv ====
// debug subsystem top: request/response cuts, DMI FSM, debug registers and halt hold-off
module dm_subsystem
  import dm_pkg::*;
#(
  parameter int unsigned HoldoffCycles = 500
) (
  input  logic      clk_i,
  input  logic      ndmreset_n,
  // DMI request channel
  input  logic      dmi_req_valid_i,
  output logic      dmi_req_ready_o,
  input  dmi_req_t  dmi_req_i,
  // DMI response channel
  output logic      dmi_resp_valid_o,
  input  logic      dmi_resp_ready_i,
  output dmi_resp_t dmi_resp_o,
  // to the core and the rest of the system
  output logic      debug_req_o,
  output logic      dm_rst_o
);

  logic                    req_cut_valid;
  logic                    req_cut_ready;
  dmi_req_t                req_cut_data;
  logic                    fsm_resp_valid;
  logic                    fsm_resp_ready;
  dmi_resp_t               fsm_resp;
  logic                    reg_en;
  logic                    reg_we;
  logic [DmiAddrWidth-1:0] reg_addr;
  logic [DmiDataWidth-1:0] reg_wdata;
  logic [DmiDataWidth-1:0] reg_rdata;
  logic                    haltreq;

  // ----------------------------------------
  // request path
  // ----------------------------------------
  dmi_cut #(
    .payload_t ( dmi_req_t )
  ) i_req_cut (
    .clk_i      ( clk_i           ),
    .ndmreset_n ( ndmreset_n      ),
    .valid_i    ( dmi_req_valid_i ),
    .ready_o    ( dmi_req_ready_o ),
    .data_i     ( dmi_req_i       ),
    .valid_o    ( req_cut_valid   ),
    .ready_i    ( req_cut_ready   ),
    .data_o     ( req_cut_data    )
  );

  dmi_fsm i_dmi_fsm (
    .clk_i        ( clk_i          ),
    .ndmreset_n   ( ndmreset_n     ),
    .req_valid_i  ( req_cut_valid  ),
    .req_ready_o  ( req_cut_ready  ),
    .req_i        ( req_cut_data   ),
    .resp_valid_o ( fsm_resp_valid ),
    .resp_ready_i ( fsm_resp_ready ),
    .resp_o       ( fsm_resp       ),
    .reg_en_o     ( reg_en         ),
    .reg_we_o     ( reg_we         ),
    .reg_addr_o   ( reg_addr       ),
    .reg_wdata_o  ( reg_wdata      ),
    .reg_rdata_i  ( reg_rdata      )
  );

  dm_regs i_dm_regs (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .reg_en_i    ( reg_en     ),
    .reg_we_i    ( reg_we     ),
    .reg_addr_i  ( reg_addr   ),
    .reg_wdata_i ( reg_wdata  ),
    .reg_rdata_o ( reg_rdata  ),
    .haltreq_o   ( haltreq    ),
    .dm_rst_o    ( dm_rst_o   )
  );

  // ----------------------------------------
  // response path
  // ----------------------------------------
  dmi_cut #(
    .payload_t ( dmi_resp_t )
  ) i_resp_cut (
    .clk_i      ( clk_i            ),
    .ndmreset_n ( ndmreset_n       ),
    .valid_i    ( fsm_resp_valid   ),
    .ready_o    ( fsm_resp_ready   ),
    .data_i     ( fsm_resp         ),
    .valid_o    ( dmi_resp_valid_o ),
    .ready_i    ( dmi_resp_ready_i ),
    .data_o     ( dmi_resp_o       )
  );

  debug_holdoff #(
    .HoldoffCycles ( HoldoffCycles )
  ) i_debug_holdoff (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .haltreq_i   ( haltreq     ),
    .debug_req_o ( debug_req_o )  // gated halt to the core
  );

endmodule

// ==== dm_assertions.sv ====
// concurrent checks on the DMI response channel and the halt hold-off, bound into dm_subsystem
module dm_assertions
  import dm_pkg::*;
#(
  parameter int unsigned HoldoffCycles = 500
) (
  input logic      clk_i,
  input logic      ndmreset_n,
  input logic      resp_valid_i,
  input logic      resp_ready_i,
  input dmi_resp_t resp_i,
  input logic      debug_req_i
);

  int unsigned released_cycles;  // edges since reset release, saturating

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_released
    if (!ndmreset_n) begin
      released_cycles <= 0;
    end else if (released_cycles < HoldoffCycles) begin
      released_cycles <= released_cycles + 1;
    end
  end

  // held response must not change until taken
  assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
    else $error("response changed while stalled");

  // window counted here, apart from the RTL counter
  assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (released_cycles < HoldoffCycles) |-> !debug_req_i)
    else $error("debug request raised during hold-off");

  // first edge after release
  assert property (@(posedge clk_i) $rose(ndmreset_n) |-> !resp_valid_i)
    else $error("response valid high right after reset");

endmodule

bind dm_subsystem dm_assertions #(
  .HoldoffCycles ( HoldoffCycles )
) i_dm_assertions (
  .clk_i          ( clk_i                      ),
  .ndmreset_n     ( ndmreset_n                 ),
  .resp_valid_i   ( dmi_resp_valid_o           ),
  .resp_ready_i   ( dmi_resp_ready_i           ),
  .resp_i         ( dmi_resp_o                 ),
  .debug_req_i    ( debug_req_o                )
);

// ==== tb_clock_gen.sv ====
// testbench clock and active-low reset generator
module tb_clock_gen #(
  parameter int unsigned Period      = 4,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic ndmreset_n_o
);

  initial begin : p_clk
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  initial begin : p_rst
    ndmreset_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    ndmreset_n_o = 1'b1;  // released between edges
  end

endmodule

// ==== tb_dm_subsystem.sv ====
// testbench top: DMI stimulus, register reference model, response checker, pass/fail report
module tb_dm_subsystem
  import dm_pkg::*;
;

  localparam int unsigned HoldoffCycles = 64;
  localparam int unsigned WaitTimeout   = 200;  // cycles per single wait

  logic      clk_i;
  logic      ndmreset_n;
  logic      dmi_req_valid_i;
  logic      dmi_req_ready_o;
  dmi_req_t  dmi_req_i;
  logic      dmi_resp_valid_o;
  logic      dmi_resp_ready_i;
  dmi_resp_t dmi_resp_o;
  logic      debug_req_o;
  logic      dm_rst_o;

  dmi_resp_t   expected_q[$];
  int unsigned cycles_since_reset;
  logic        random_ready;
  // model of the register rules
  logic [DmiDataWidth-1:0] model_data0;
  logic                    model_active;
  logic                    model_ndmreset;
  logic                    model_haltreq;

  tb_clock_gen #(.Period(4), .ResetCycles(16)) i_clock_gen (
    .clk_o        ( clk_i      ),
    .ndmreset_n_o ( ndmreset_n )
  );

  dm_subsystem #(.HoldoffCycles(HoldoffCycles)) dut0 (
    .clk_i            ( clk_i            ),
    .ndmreset_n       ( ndmreset_n       ),
    .dmi_req_valid_i  ( dmi_req_valid_i  ),
    .dmi_req_ready_o  ( dmi_req_ready_o  ),
    .dmi_req_i        ( dmi_req_i        ),
    .dmi_resp_valid_o ( dmi_resp_valid_o ),
    .dmi_resp_ready_i ( dmi_resp_ready_i ),
    .dmi_resp_o       ( dmi_resp_o       ),
    .debug_req_o      ( debug_req_o      ),
    .dm_rst_o         ( dm_rst_o         )
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic dmi_req_t make_req(input logic [DmiAddrWidth-1:0] addr, input dmi_op_e op,
                                        input logic [DmiDataWidth-1:0] data);
    dmi_req_t req;
    req.addr = addr;
    req.op   = op;
    req.data = data;
    return req;
  endfunction

  // expected answer, applies writes to the model in request order
  function automatic dmi_resp_t expected_response(input dmi_req_t req);
    dmi_resp_t r;
    r.data = '0;
    r.resp = DmiRespOk;
    if (req.op == DmiRead) begin
      if (req.addr == AddrData0) begin
        r.data = model_data0;
      end else if (req.addr == AddrDmControl) begin
        r.data[DmControlActiveBit]   = model_active;
        r.data[DmControlNdmresetBit] = model_ndmreset;
        r.data[DmControlHaltreqBit]  = model_haltreq;
      end else if (req.addr == AddrDmStatus) begin
        r.data = 32'h0000_0082;  // version 2, authenticated
      end
    end else if (req.op == DmiWrite) begin
      if (req.addr == AddrData0) begin
        model_data0 = req.data;
      end else if (req.addr == AddrDmControl) begin
        model_active   = req.data[DmControlActiveBit];
        model_ndmreset = req.data[DmControlActiveBit] & req.data[DmControlNdmresetBit];
        model_haltreq  = req.data[DmControlActiveBit] & req.data[DmControlHaltreqBit];
      end
    end else if (req.op == DmiReserved) begin
      r.resp = DmiRespFailed;
    end
    return r;
  endfunction

  // called at a falling edge, returns at the falling edge after the transfer
  task automatic send_request(input dmi_req_t req);
    int unsigned waited;
    waited          = 0;
    dmi_req_valid_i = 1'b1;
    dmi_req_i       = req;
    while (!dmi_req_ready_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > WaitTimeout) begin
        $display("timeout waiting for the request to be accepted");
        stop_with_failure();
      end
    end
    @(negedge clk_i);
    expected_q.push_back(expected_response(req));
    dmi_req_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    int unsigned waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > 4 * WaitTimeout) begin
        $display("timeout waiting for outstanding responses");
        stop_with_failure();
      end
    end
  endtask

  // ----------------------------------------
  // response side
  // ----------------------------------------
  initial begin : p_resp_ready
    random_ready     = 1'b0;
    dmi_resp_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      dmi_resp_ready_i = random_ready ? ($urandom_range(0, 2) == 0) : 1'b1;
    end
  end

  always @(posedge clk_i or negedge ndmreset_n) begin : p_cycles
    if (!ndmreset_n) cycles_since_reset <= 0;
    else cycles_since_reset <= cycles_since_reset + 1;
  end

  always @(posedge clk_i) begin : p_compare
    dmi_resp_t exp_resp;
    if (ndmreset_n && dmi_resp_valid_o && dmi_resp_ready_i) begin
      if (expected_q.size() == 0) begin
        $display("response returned with no request outstanding");
        stop_with_failure();
      end else begin
        exp_resp = expected_q.pop_front();
        check_value("dmi_resp_o.data", dmi_resp_o.data, exp_resp.data);
        check_value("dmi_resp_o.resp", dmi_resp_o.resp, exp_resp.resp);
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin : p_stimulus
    logic [DmiDataWidth-1:0]  wdata;
    logic [DmiAddrWidth-1:0]  addr;
    logic [DmiDataWidth-1:0]  ctrl_vals[4];
    int unsigned              waited;
    void'($urandom(32'h3394_132b));
    dmi_req_valid_i = 1'b0;
    dmi_req_i       = '0;
    model_data0     = '0;
    model_active    = 1'b0;
    model_ndmreset  = 1'b0;
    model_haltreq   = 1'b0;
    ctrl_vals       = '{32'h8000_0003, 32'hffff_fffe, 32'h7fff_ffff, 32'h0000_0001};
    waited = 0;
    while (!ndmreset_n) begin
      @(negedge clk_i);
      waited++;
      if (waited > WaitTimeout) begin
        $display("timeout waiting for reset release");
        stop_with_failure();
      end
    end
    // halt request must wait out the hold-off window
    send_request(make_req(AddrDmControl, DmiWrite, 32'h8000_0001));
    waited = 0;
    while (cycles_since_reset < 2 * HoldoffCycles) begin
      if (cycles_since_reset < HoldoffCycles) check_value("debug_req_o", debug_req_o, 1'b0);
      @(negedge clk_i);
      waited++;
      if (waited > 4 * HoldoffCycles) begin
        $display("timeout waiting for the hold-off window to pass");
        stop_with_failure();
      end
    end
    check_value("debug_req_o", debug_req_o, 1'b1);
    wait_drained();
    for (int i = 0; i < 8; i++) begin  // data0 write/read
      wdata = $urandom();
      send_request(make_req(AddrData0, DmiWrite, wdata));
      send_request(make_req(AddrData0, DmiRead, '0));
    end
    foreach (ctrl_vals[i]) begin
      send_request(make_req(AddrDmControl, DmiWrite, ctrl_vals[i]));
      send_request(make_req(AddrDmControl, DmiRead, '0));
      wait_drained();
      check_value("dm_rst_o", dm_rst_o, model_ndmreset);
      check_value("debug_req_o", debug_req_o, model_haltreq & model_active);
    end
    send_request(make_req(AddrDmStatus, DmiWrite, 32'hdead_beef));
    send_request(make_req(AddrDmStatus, DmiRead, '0));
    send_request(make_req(7'h20, DmiWrite, 32'h1234_5678));
    send_request(make_req(7'h20, DmiRead, '0));
    send_request(make_req(7'h7f, DmiRead, '0));
    send_request(make_req(AddrData0, DmiNop, 32'hffff_ffff));
    send_request(make_req(AddrData0, DmiReserved, 32'hffff_ffff));
    wait_drained();
    random_ready = 1'b1;  // back-pressure on responses
    for (int i = 0; i < 60; i++) begin
      case ($urandom_range(0, 3))
        0: addr = AddrData0;
        1: addr = AddrDmControl;
        2: addr = AddrDmStatus;
        default: addr = 7'($urandom_range(32, 127));
      endcase
      send_request(make_req(addr, dmi_op_e'($urandom_range(0, 3)), $urandom()));
    end
    wait_drained();
    random_ready = 1'b0;
    // no extra response may follow the last answered request
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_i);
      check_value("dmi_resp_valid_o", dmi_resp_valid_o, 1'b0);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== compile.f ====
dm_pkg.sv
dmi_cut.sv
dmi_fsm.sv
dm_regs.sv
debug_holdoff.sv
dm_subsystem.sv
dm_assertions.sv
tb_clock_gen.sv
tb_dm_subsystem.sv
